/* tests/board_audio_patterns.txt */
// mic sample (24 bit), gain shift, expected sound (16 bit), expected led
// sound = top 16 bits shifted by gain and saturated; led = thermometer of sound level
000000 0 0000 00
0012ab 0 0012 00
0a0000 0 0a00 0f
1234cd 0 1234 1f
fedcba 0 fedc 01
7fffff 0 7fff 7f
800000 0 8000 7f
012345 1 0246 03
3fff00 1 7ffe 7f
400000 1 7fff 7f
c00000 1 8000 7f
bfff80 1 8000 7f
0f0f0f 2 3c3c 3f
ffe000 2 ff80 00
2000aa 2 7fff 7f
0abcde 3 55e0 7f
f00000 3 8000 7f
00c000 3 0600 07

/* board_audio.f */
verilog/board_audio_pkg.sv
verilog/i2s_timing_if.sv
verilog/i2s_timing_ctrl.sv
verilog/mic_i2s_receiver.sv
verilog/audio_gain_stage.sv
verilog/i2s_audio_out.sv
verilog/board_audio_top.sv
tests/board_audio_tb.sv

/* tests/board_audio_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module board_audio_tb;

    import board_audio_pkg::*;

    localparam sck_half_period = 4;
    localparam w_led           = 8;
    localparam n_pat           = 18;                          // Lines in pattern file
    localparam frame_cycles    = 64 * 2 * sck_half_period;
    localparam timeout_cycles  = (n_pat + 3) * frame_cycles * 2;

    logic                clk;
    logic                rst;
    logic [w_gain - 1:0] sw;
    logic                mic_sd;
    logic                mic_sck;
    logic                mic_ws;
    logic                mic_lr;
    logic                dac_bclk;
    logic                dac_lrclk;
    logic                dac_sdata;
    logic [w_led - 1:0]  led;

    logic [23:0] pat_mem [0:n_pat * 4 - 1];                   // sample, gain, sound, led
    int          test_err [0:n_pat - 1];
    int          errors       = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          timing_err   = 0;
    int          before_main;
    int          before_fall;
    int          low_cyc;
    int          cycles;
    int          k;

    // Bit clock follower state
    logic        sck_seen   = 1'b0;
    logic        ws_seen    = 1'b0;
    logic        have_fall  = 1'b0;
    int          bit_pos    = 0;                              // 0 .. 31 in slot
    int          frame      = 0;
    int          period_cyc = 0;
    int          high_cyc   = 0;
    int          slots_seen = 0;

    // DAC capture state
    logic        cap_ws     = 1'b0;
    int          cap_pos    = -1;
    logic [15:0] dac_left   = '0;
    logic [15:0] dac_right  = '0;

    board_audio_top
    #(
        .sck_half_period ( sck_half_period ),
        .w_led           ( w_led           )
    )
    board_audio_top_i
    (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .sw        ( sw        ),
        .mic_sd    ( mic_sd    ),
        .mic_sck   ( mic_sck   ),
        .mic_ws    ( mic_ws    ),
        .mic_lr    ( mic_lr    ),
        .dac_bclk  ( dac_bclk  ),
        .dac_lrclk ( dac_lrclk ),
        .dac_sdata ( dac_sdata ),
        .led       ( led       )
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;                                // 10 ns period
    end

    // ----------------------------------------
    // Checking and reporting
    // ----------------------------------------

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int fails);
        if (fails == 0)
        begin
            tests_passed++;
            $display("test %s: pass", name);
        end
        else
        begin
            tests_failed++;
            $display("test %s: fail with %0d mismatches", name, fails);
        end
    endtask

    // ----------------------------------------
    // Microphone model and bit clock timing
    // ----------------------------------------

    always @(negedge clk)
    begin
        period_cyc++;
        if (mic_sck === 1'b1)
            high_cyc++;
        if (sck_seen === 1'b1 && mic_sck === 1'b0)             // Bit clock just fell
        begin
            before_fall = errors;
            if (have_fall)
                check_value("mic_sck period", 2 * sck_half_period, period_cyc);
            check_value("mic_sck high time", sck_half_period, high_cyc);
            check_value("dac_bclk", mic_sck, dac_bclk);
            check_value("dac_lrclk", mic_ws, dac_lrclk);
            if (mic_ws !== ws_seen)
            begin
                check_value("mic_ws slot length", 32, bit_pos + 1);
                bit_pos = 0;
                slots_seen++;
                if (mic_ws === 1'b0)                           // New frame
                begin
                    frame++;
                    if (frame < n_pat)
                        sw = pat_mem[frame * 4 + 1][w_gain - 1:0];
                end
            end
            else
                bit_pos++;
            timing_err += errors - before_fall;

            // One-bit delay, MSB at slot position 1
            if (mic_ws === 1'b0 && bit_pos >= 1 && bit_pos <= 24 && frame < n_pat)
                mic_sd = pat_mem[frame * 4][24 - bit_pos];
            else
                mic_sd = 1'b0;

            period_cyc = 0;
            high_cyc   = 0;
            have_fall  = 1'b1;
            ws_seen    = mic_ws;
        end
        sck_seen = mic_sck;
    end

    // DAC side, both slots
    always @(posedge dac_bclk)
    begin
        if (dac_lrclk !== cap_ws)
            cap_pos = 0;
        else
            cap_pos++;
        cap_ws = dac_lrclk;
        if (cap_pos >= 1 && cap_pos <= 16)
        begin
            if (dac_lrclk)
                dac_right = {dac_right[14:0], dac_sdata};
            else
                dac_left  = {dac_left[14:0], dac_sdata};
        end
    end

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------

    initial
    begin
        rst    = 1'b1;
        sw     = '0;
        mic_sd = 1'b0;
        for (int i = 0; i < n_pat; i++)
            test_err[i] = 0;

        $readmemh("tests/board_audio_patterns.txt", pat_mem);
        if ($isunknown(pat_mem[n_pat * 4 - 1]))
        begin
            $display("Pattern file tests/board_audio_patterns.txt could not be read in full");
            errors++;
        end
        sw = pat_mem[1][w_gain - 1:0];                        // Gain for frame 0

        repeat (4) @(negedge clk);
        rst = 1'b0;

        // Quiet outputs until the first bit clock rise
        before_main = errors;
        low_cyc     = 0;
        while (mic_sck === 1'b0 && low_cyc < 4 * sck_half_period)
        begin
            check_value("dac_sdata", 0, dac_sdata);
            check_value("led", 0, led);
            check_value("mic_ws", 0, mic_ws);
            check_value("mic_lr", 0, mic_lr);
            low_cyc++;
            @(negedge clk);
        end
        check_value("mic_sck low cycles after reset", sck_half_period, low_cyc);
        report_test("reset state", errors - before_main);

        // Frame k shows led of pattern k-1 and DAC words of pattern k-2
        for (k = 1; k <= n_pat + 1; k++)
        begin
            wait (frame == k);
            if (k <= n_pat)
            begin
                before_main = errors;
                check_value("led", pat_mem[(k - 1) * 4 + 3], led);
                test_err[k - 1] += errors - before_main;
            end
            if (k >= 2)
            begin
                before_main = errors;
                check_value("dac_sdata left slot", pat_mem[(k - 2) * 4 + 2], dac_left);
                check_value("dac_sdata right slot", pat_mem[(k - 2) * 4 + 2], dac_right);
                test_err[k - 2] += errors - before_main;
                report_test($sformatf("%0d sample %h gain %0d", k - 2, pat_mem[(k - 2) * 4],
                            pat_mem[(k - 2) * 4 + 1]), test_err[k - 2]);
            end
        end

        report_test($sformatf("bit clock timing over %0d slots", slots_seen), timing_err);
        $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

    // Run limit
    initial
    begin
        cycles = 0;
        while (cycles < timeout_cycles)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the frames did not complete within %0d clock cycles", cycles);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/board_audio_top.sv */
`timescale 1ns/1ps
`default_nettype none

module board_audio_top
#(
    parameter sck_half_period = 4,
              w_led           = 8
)
(
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [board_audio_pkg::w_gain - 1:0] sw,          // Gain select

    input  logic                                 mic_sd,
    output logic                                 mic_sck,
    output logic                                 mic_ws,
    output logic                                 mic_lr,

    output logic                                 dac_bclk,
    output logic                                 dac_lrclk,
    output logic                                 dac_sdata,

    output logic [w_led - 1:0]                   led
);

    import board_audio_pkg::*;

    logic [w_mic - 1:0]   mic_sample;
    logic                 mic_valid;
    logic [w_sound - 1:0] sound;

    i2s_timing_if tm ();                         // Shared by mic and DAC

    // ----------------------------------------
    // Timing and datapath
    // ----------------------------------------

    i2s_timing_ctrl
    #(
        .sck_half_period ( sck_half_period )
    )
    i_timing
    (
        .clk ( clk ),
        .rst ( rst ),
        .tm  ( tm  )
    );

    mic_i2s_receiver i_microphone
    (
        .clk          ( clk        ),
        .rst          ( rst        ),
        .tm           ( tm         ),
        .sd           ( mic_sd     ),
        .sample       ( mic_sample ),
        .sample_valid ( mic_valid  )
    );

    audio_gain_stage
    #(
        .w_led ( w_led )
    )
    i_gain
    (
        .clk          ( clk        ),
        .rst          ( rst        ),
        .sample       ( mic_sample ),
        .sample_valid ( mic_valid  ),
        .gain         ( sw         ),
        .sound        ( sound      ),
        .led          ( led        )
    );

    i2s_audio_out i_audio_out
    (
        .clk   ( clk       ),
        .rst   ( rst       ),
        .tm    ( tm        ),
        .sound ( sound     ),
        .sdata ( dac_sdata )
    );

    // ----------------------------------------
    // Pins
    // ----------------------------------------

    assign mic_sck   = tm.sck;
    assign dac_bclk  = tm.sck;                   // One bit clock for both
    assign mic_ws    = tm.ws;
    assign dac_lrclk = tm.ws;
    assign mic_lr    = 1'b0;                     // Mic answers in left slot

    // Samples only ever complete inside the left slot
    a_valid_in_left : assert property (
        @(posedge clk) disable iff (rst)
        mic_valid |-> !tm.ws
    );

endmodule

`default_nettype wire

/* verilog/i2s_audio_out.sv */
`timescale 1ns/1ps
`default_nettype none

module i2s_audio_out
(
    input  logic                                  clk,
    input  logic                                  rst,
    i2s_timing_if.tx                              tm,
    input  logic [board_audio_pkg::w_sound - 1:0] sound,
    output logic                                  sdata          // To DAC
);

    import board_audio_pkg::*;

    logic [w_sound - 1:0] word;                  // Held for whole frame
    i2s_slot_t            shifter;
    logic                 slot_start;            // First fall of a slot
    logic                 frame_start;           // ws falling
    logic                 in_data;               // Bit indices 1 to 16

    assign slot_start  = tm.sck_fall && (tm.bit_idx == '0);
    assign frame_start = slot_start & ~tm.ws;
    assign in_data     = (tm.bit_idx >= w_bit_idx'(data_first_bit))
                      && (tm.bit_idx <= w_bit_idx'(dac_last_bit));

    // ----------------------------------------
    // Word latch and slot shifter
    // ----------------------------------------

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            word <= '0;
        else if (frame_start)
            word <= sound;                       // Same word in both slots
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            shifter <= '0;
            sdata   <= 1'b0;
        end
        else if (tm.sck_fall)
        begin
            if (slot_start)
            begin
                shifter.dac.data <= frame_start ? sound : word;   // Bypass on new frame
                shifter.dac.pad  <= '0;
            end
            else if (in_data)
                shifter.dac.data <= {shifter.dac.data[w_sound - 2:0], 1'b0};

            sdata <= in_data ? shifter.dac.data[w_sound - 1] : 1'b0;   // Zero tail
        end
    end

    // Slot position must only move with a bit clock fall, or a slot start is missed
    a_idx_on_fall : assert property (
        @(posedge clk) disable iff (rst)
        $changed(tm.bit_idx) |-> tm.sck_fall
    );

endmodule

`default_nettype wire

/* verilog/audio_gain_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module audio_gain_stage
#(
    parameter w_led = 8
)
(
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [board_audio_pkg::w_mic   - 1:0] sample,
    input  logic                                  sample_valid,
    input  logic [board_audio_pkg::w_gain  - 1:0] gain,        // Left shift amount
    output logic [board_audio_pkg::w_sound - 1:0] sound,
    output logic [w_led - 1:0]                    led           // Thermometer meter
);

    import board_audio_pkg::*;

    // Headroom for the largest shift
    localparam w_wide = w_sound + (1 << w_gain) - 1;
    localparam logic signed [w_wide - 1:0] sound_max = w_wide'(2 ** (w_sound - 1) - 1);
    localparam logic signed [w_wide - 1:0] sound_min = -sound_max - 1;

    logic signed [w_wide - 1:0] top_ext;         // Top 16 bits, sign extended
    logic signed [w_wide - 1:0] scaled;
    logic        [w_sound - 1:0] sat;            // Clamped to 16 bits
    logic        [w_led - 1:0]   led_next;
    logic                        run_open;       // Still inside sign run
    int                          sign_run;       // Leading sign-equal bits
    int                          lit;            // LEDs to light

    // ----------------------------------------
    // Gain and saturation
    // ----------------------------------------

    assign top_ext = {{(w_wide - w_sound){sample[w_mic - 1]}}, sample[w_mic - 1 -: w_sound]};
    assign scaled  = top_ext <<< gain;

    always_comb
    begin
        if (scaled > sound_max)
            sat = {1'b0, {(w_sound - 1){1'b1}}};      // +32767
        else if (scaled < sound_min)
            sat = {1'b1, {(w_sound - 1){1'b0}}};      // -32768
        else
            sat = scaled[w_sound - 1:0];
    end

    // ----------------------------------------
    // Level meter
    // ----------------------------------------

    // Sign bit counts as the first member of the run
    always_comb
    begin
        sign_run = 0;
        run_open = 1'b1;
        for (int i = w_sound - 1; i >= 0; i--)
        begin
            if (run_open && (sat[i] == sat[w_sound - 1]))
                sign_run++;
            else
                run_open = 1'b0;
        end

        lit = w_led - sign_run;
        if (lit < 0)
            lit = 0;                             // Quiet
        if (lit > w_led)
            lit = w_led;

        for (int i = 0; i < w_led; i++)
            led_next[i] = (i < lit);
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            sound <= '0;
            led   <= '0;
        end
        else if (sample_valid)
        begin
            sound <= sat;                        // Held until next sample
            led   <= led_next;
        end
    end

endmodule

`default_nettype wire

/* verilog/mic_i2s_receiver.sv */
`timescale 1ns/1ps
`default_nettype none

module mic_i2s_receiver
(
    input  logic                              clk,
    input  logic                              rst,
    i2s_timing_if.rx                          tm,
    input  logic                              sd,            // Mic data line
    output logic [board_audio_pkg::w_mic - 1:0] sample,
    output logic                              sample_valid   // One pulse per frame
);

    import board_audio_pkg::*;

    i2s_slot_t slot;                             // Capture register
    i2s_slot_t slot_next;                        // Slot after this bit
    logic      in_data;                          // Left slot data bit
    logic      capture;                          // Shift this cycle
    logic      last_bit;                         // LSB of 24-bit sample

    // ----------------------------------------
    // Bit selection
    // ----------------------------------------

    assign in_data  = ~tm.ws
                    && (tm.bit_idx >= w_bit_idx'(data_first_bit))
                    && (tm.bit_idx <= w_bit_idx'(mic_last_bit));
    assign last_bit = (tm.bit_idx == w_bit_idx'(mic_last_bit));
    assign capture  = tm.sck_rise & in_data;     // Right channel ignored

    always_comb
    begin
        slot_next          = slot;
        slot_next.mic.data = {slot.mic.data[w_mic - 2:0], sd};   // MSB first
        slot_next.mic.pad  = '0;
    end

    // ----------------------------------------
    // Shift and output
    // ----------------------------------------

    always_ff @(posedge clk)
    begin
        if (capture)
            slot <= slot_next;
    end

    always_ff @(posedge clk)
    begin
        if (capture & last_bit)
            sample <= slot_next.mic.data;        // Includes the final bit
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            sample_valid <= 1'b0;
        else
            sample_valid <= capture & last_bit;
    end

    a_valid_single : assert property (
        @(posedge clk) disable iff (rst)
        sample_valid |=> !sample_valid
    );

endmodule

`default_nettype wire

/* verilog/i2s_timing_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module i2s_timing_ctrl
#(
    parameter sck_half_period = 4                // clk cycles per sck half
)
(
    input  logic       clk,
    input  logic       rst,
    i2s_timing_if.ctrl tm
);

    import board_audio_pkg::*;

    localparam w_hp = $clog2(sck_half_period + 1);

    logic [w_hp - 1:0]        hp_cnt;            // Position inside half period
    logic                     hp_done;           // Last cycle of half period
    logic [w_frame_cnt - 1:0] frame_cnt;         // 64 bit clocks per frame

    // ----------------------------------------
    // Bit clock divider
    // ----------------------------------------

    assign hp_done = (hp_cnt == w_hp'(sck_half_period - 1));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            hp_cnt <= '0;
        else if (hp_done)
            hp_cnt <= '0;                        // Wrap
        else
            hp_cnt <= hp_cnt + 1'b1;
    end

    // Strobes line up with the new sck level
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            tm.sck      <= 1'b0;
            tm.sck_rise <= 1'b0;
            tm.sck_fall <= 1'b0;
        end
        else
        begin
            tm.sck_rise <= hp_done & ~tm.sck;    // Low going high
            tm.sck_fall <= hp_done &  tm.sck;    // High going low

            if (hp_done)
                tm.sck <= ~tm.sck;
        end
    end

    // ----------------------------------------
    // Frame position
    // ----------------------------------------

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            frame_cnt <= '0;                     // Left slot, bit 0
        else if (hp_done & tm.sck)
            frame_cnt <= frame_cnt + 1'b1;       // Same edge as sck_fall
    end

    assign tm.ws      = frame_cnt[w_frame_cnt - 1];
    assign tm.bit_idx = frame_cnt[w_bit_idx - 1:0];

    // High phase of the bit clock lasts exactly one half period
    a_half_period : assert property (
        @(posedge clk) disable iff (rst)
        tm.sck_fall |-> $past(tm.sck_rise, sck_half_period)
    );

endmodule

`default_nettype wire

/* verilog/i2s_timing_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface i2s_timing_if;

    import board_audio_pkg::*;

    // ----------------------------------------
    // Shared bit clock and slot timing
    // ----------------------------------------

    logic                   sck;                 // Bit clock level
    logic                   sck_rise;            // High in first cycle of sck high
    logic                   sck_fall;            // High in first cycle of sck low
    logic                   ws;                  // Low for left slot
    logic [w_bit_idx - 1:0] bit_idx;             // Changes with sck_fall only

    modport ctrl
    (
        output sck,
        output sck_rise,
        output sck_fall,
        output ws,
        output bit_idx
    );

    modport rx                                   // Microphone side
    (
        input  sck_rise,
        input  ws,
        input  bit_idx
    );

    modport tx                                   // DAC side
    (
        input  sck_fall,
        input  ws,
        input  bit_idx
    );

endinterface

`default_nettype wire

/* verilog/board_audio_pkg.sv */
`default_nettype none

package board_audio_pkg;

    // ----------------------------------------
    // Sample and word widths
    // ----------------------------------------

    localparam w_mic   = 24;                     // INMP441 sample
    localparam w_sound = 16;                     // DAC word
    localparam w_slot  = 32;                     // Bits per channel slot
    localparam w_gain  = 2;                      // Gain switch field

    // ----------------------------------------
    // Frame geometry
    // ----------------------------------------

    localparam w_bit_idx   = $clog2(w_slot);     // 0 .. 31 within a slot
    localparam w_frame_cnt = w_bit_idx + 1;      // Top bit is ws

    // I2S one-bit delay puts the MSB at bit index 1
    localparam data_first_bit = 1;
    localparam mic_last_bit   = data_first_bit + w_mic - 1;    // 24
    localparam dac_last_bit   = data_first_bit + w_sound - 1;  // 16

    // ----------------------------------------
    // Slot shift register views
    // ----------------------------------------

    typedef struct packed {
        logic [w_mic - 1:0]          data;       // MSB first
        logic [w_slot - w_mic - 1:0] pad;        // Trailing zeros
    } mic_view_t;

    typedef struct packed {
        logic [w_sound - 1:0]          data;     // MSB first
        logic [w_slot - w_sound - 1:0] pad;      // Idle tail of slot
    } dac_view_t;

    // Same 32 bits, read by the receiver or loaded by the transmitter
    typedef union packed {
        mic_view_t mic;
        dac_view_t dac;
    } i2s_slot_t;

endpackage

`default_nettype wire
